// File: hw/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DC_LINES    128
`define DC_WORDS    16

// Address fields, tag above index above word offset
`define DC_INDEX_W  7
`define DC_OFFSET_W 4
`define DC_TAG_W    19
`define DC_ADDR_W   32

`endif

// File: hw/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    // Byte address and data word
    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [31:0]             word_t;
    typedef logic [3:0]              byte_en_t;   // One bit per byte lane

    // Address fields
    typedef logic [`DC_TAG_W-1:0]    tag_t;       // Bits 31..13
    typedef logic [`DC_INDEX_W-1:0]  index_t;     // Bits 12..6
    typedef logic [`DC_OFFSET_W-1:0] offset_t;    // Bits 5..2

    // Whole line as seen across the word banks
    typedef word_t line_t [`DC_WORDS];

endpackage

`default_nettype wire

// File: hw/tag_store.sv
`default_nettype none

module tag_store #(
    parameter int LINES = 2 ** $bits(dcache_pkg::index_t)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::addr_t    addr,
    input  logic                 store_hit,
    input  logic                 fill_commit,
    input  dcache_pkg::byte_en_t be,
    output logic                 hit,
    output logic                 victim_dirty,
    output dcache_pkg::tag_t     victim_tag
);
    import dcache_pkg::*;

    localparam int IDX_LSB = $bits(offset_t) + 2;
    localparam int TAG_LSB = IDX_LSB + $bits(index_t);

    logic [LINES-1:0] valid;
    logic [LINES-1:0] dirty;
    tag_t             tags [LINES];
    index_t           index;
    tag_t             tag;

    assign index = addr[IDX_LSB +: $bits(index_t)];
    assign tag   = addr[TAG_LSB +: $bits(tag_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_commit) begin
            valid[index] <= 1'b1;
            dirty[index] <= |be;    // Store miss leaves the new line dirty
        end else if (store_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_commit) begin
            tags[index] <= tag;
        end
    end

    assign hit          = valid[index] && (tags[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag   = tags[index];

endmodule

`default_nettype wire

// File: hw/word_bank.sv
`default_nettype none

// One word column of the data array, one entry per line
module word_bank #(
    parameter int LINES = 2 ** $bits(dcache_pkg::index_t)
) (
    input  logic                 clk,
    input  dcache_pkg::index_t   index,
    input  logic                 we,
    input  dcache_pkg::byte_en_t be,
    input  dcache_pkg::word_t    wdata,
    output dcache_pkg::word_t    rdata
);
    import dcache_pkg::*;

    word_t mem [LINES];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (be[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read
    assign rdata = mem[index];

endmodule

`default_nettype wire

// File: hw/line_fill.sv
`default_nettype none

module line_fill (
    input  logic                                      clk,
    input  logic                                      rst,
    input  dcache_pkg::addr_t                         addr,
    input  dcache_pkg::byte_en_t                      be,
    input  dcache_pkg::word_t                         wdata,
    input  logic                                      fill_active,
    input  logic                                      store_hit,
    input  logic                                      fill_commit,
    input  dcache_pkg::word_t                         rd_data,
    input  logic                                      rd_valid,
    input  logic                                      rd_last,
    output logic                                      fill_done,
    output dcache_pkg::word_t                         fill_word,
    output logic [2**$bits(dcache_pkg::offset_t)-1:0] bank_we,
    output dcache_pkg::byte_en_t                      bank_be,
    output dcache_pkg::line_t                         bank_wdata
);
    import dcache_pkg::*;

    localparam int WORDS = 2 ** $bits(offset_t);

    word_t   rx_buf [WORDS];
    offset_t beat_cnt;
    offset_t offset;
    word_t   merged;

    assign offset = addr[2 +: $bits(offset_t)];

    // Store bytes override the matching lanes of the beat
    always_comb begin
        merged = rd_data;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !fill_active) begin
            beat_cnt <= '0;
        end else if (rd_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_active && rd_valid) begin
            rx_buf[beat_cnt] <= (beat_cnt == offset) ? merged : rd_data;
        end
    end

    assign fill_done = fill_active && rd_valid && rd_last;
    assign fill_word = rx_buf[offset];

    // Commit writes the whole line, a store hit only its own word
    always_comb begin
        for (int w = 0; w < WORDS; w++) begin
            bank_we[w]    = fill_commit || (store_hit && offset == offset_t'(w));
            bank_wdata[w] = fill_commit ? rx_buf[w] : wdata;
        end
    end

    assign bank_be = fill_commit ? byte_en_t'('1) : be;

endmodule

`default_nettype wire

// File: hw/line_writeback.sv
`default_nettype none

module line_writeback (
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_start,
    input  dcache_pkg::tag_t  victim_tag,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::line_t line_data,
    input  logic              wr_req_ok,
    input  logic              wr_ready,
    input  logic              wr_resp,
    output logic              wb_busy,
    output logic              wr_req,
    output dcache_pkg::addr_t wr_addr,
    output dcache_pkg::word_t wr_data,
    output logic              wr_valid,
    output logic              wr_last
);
    import dcache_pkg::*;

    localparam int IDX_LSB = $bits(offset_t) + 2;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_REQ,
        WB_SEND,
        WB_RESP
    } wb_state_t;

    wb_state_t state;
    wb_state_t state_nxt;
    offset_t   beat_cnt;
    addr_t     victim_addr;
    addr_t     start_addr;

    // Victim line address, tag from the store and index from the access
    assign start_addr = {victim_tag, addr[IDX_LSB +: $bits(index_t)], {IDX_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WB_IDLE && wb_start) begin
            victim_addr <= start_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != WB_SEND) begin
            beat_cnt <= '0;
        end else if (wr_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WB_IDLE: if (wb_start) state_nxt = wr_req_ok ? WB_SEND : WB_REQ;
            WB_REQ:  if (wr_req_ok) state_nxt = WB_SEND;
            WB_SEND: if (wr_ready && wr_last) state_nxt = WB_RESP;
            WB_RESP: if (wr_resp) state_nxt = WB_IDLE;
            default: state_nxt = WB_IDLE;
        endcase
    end

    assign wr_req   = (state == WB_IDLE && wb_start) || state == WB_REQ;
    assign wr_addr  = (state == WB_IDLE) ? start_addr : victim_addr;
    assign wr_valid = state == WB_SEND;
    assign wr_last  = wr_valid && (&beat_cnt);
    assign wr_data  = line_data[beat_cnt];     // Banks hold the victim until commit
    assign wb_busy  = state != WB_IDLE;

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  dcache_pkg::addr_t    addr,
    input  dcache_pkg::byte_en_t be,
    input  logic                 hit,
    input  logic                 victim_dirty,
    input  dcache_pkg::line_t    line_data,
    input  dcache_pkg::word_t    fill_word,
    input  logic                 fill_done,
    input  logic                 wb_busy,
    input  logic                 rd_req_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 busy,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    output logic                 store_hit,
    output logic                 fill_active,
    output logic                 fill_commit,
    output logic                 wb_start
);
    import dcache_pkg::*;

    localparam int LINE_LSB = $bits(offset_t) + 2;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_SHAKE,
        S_RD_WAIT,
        S_WB_WAIT,
        S_COMMIT
    } state_t;

    state_t  state;
    state_t  state_nxt;
    offset_t offset;
    logic    is_store;
    logic    access_hit;
    logic    miss;

    assign offset     = addr[2 +: $bits(offset_t)];
    assign is_store   = |be;
    assign access_hit = (state == S_IDLE) && req && hit;
    assign miss       = (state == S_IDLE) && req && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (miss) begin
                    state_nxt = rd_req_ok ? S_RD_WAIT : S_RD_SHAKE;
                end
            end
            S_RD_SHAKE: begin
                if (rd_req_ok) begin
                    state_nxt = S_RD_WAIT;
                end
            end
            S_RD_WAIT: begin
                // Refill may finish before or after the writeback
                if (fill_done) begin
                    state_nxt = wb_busy ? S_WB_WAIT : S_COMMIT;
                end
            end
            S_WB_WAIT: begin
                if (!wb_busy) begin
                    state_nxt = S_COMMIT;
                end
            end
            S_COMMIT: state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    // Read request goes out in the miss cycle itself
    assign rd_req  = miss || state == S_RD_SHAKE;
    assign rd_addr = {addr[$bits(addr_t)-1:LINE_LSB], {LINE_LSB{1'b0}}};

    assign wb_start    = miss && victim_dirty;   // Same cycle as the read request
    assign fill_active = state == S_RD_WAIT;
    assign fill_commit = state == S_COMMIT;
    assign store_hit   = access_hit && is_store;

    assign data_ok = access_hit || fill_commit;
    assign rdata   = fill_commit ? fill_word : line_data[offset];
    assign busy    = miss || state != S_IDLE;

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  dcache_pkg::addr_t    addr,
    input  dcache_pkg::byte_en_t be,
    input  dcache_pkg::word_t    wdata,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 busy,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_req_ok,
    input  dcache_pkg::word_t    rd_data,
    input  logic                 rd_valid,
    input  logic                 rd_last,
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    input  logic                 wr_req_ok,
    output dcache_pkg::word_t    wr_data,
    output logic                 wr_valid,
    output logic                 wr_last,
    input  logic                 wr_ready,
    input  logic                 wr_resp
);
    import dcache_pkg::*;

    logic                 hit;
    logic                 victim_dirty;
    tag_t                 victim_tag;
    logic                 store_hit;
    logic                 fill_commit;
    logic                 fill_active;
    logic                 fill_done;
    word_t                fill_word;
    logic                 wb_start;
    logic                 wb_busy;
    logic [`DC_WORDS-1:0] bank_we;
    byte_en_t             bank_be;
    line_t                bank_wdata;
    line_t                line_data;
    index_t               index;

    assign index = addr[`DC_OFFSET_W + 2 +: `DC_INDEX_W];

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .be           (be),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .line_data    (line_data),
        .fill_word    (fill_word),
        .fill_done    (fill_done),
        .wb_busy      (wb_busy),
        .rd_req_ok    (rd_req_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .busy         (busy),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .store_hit    (store_hit),
        .fill_active  (fill_active),
        .fill_commit  (fill_commit),
        .wb_start     (wb_start)
    );

    tag_store #(
        .LINES (`DC_LINES)
    ) i_tags (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .store_hit    (store_hit),
        .fill_commit  (fill_commit),
        .be           (be),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    line_fill i_fill (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .be          (be),
        .wdata       (wdata),
        .fill_active (fill_active),
        .store_hit   (store_hit),
        .fill_commit (fill_commit),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .rd_last     (rd_last),
        .fill_done   (fill_done),
        .fill_word   (fill_word),
        .bank_we     (bank_we),
        .bank_be     (bank_be),
        .bank_wdata  (bank_wdata)
    );

    line_writeback i_wb (
        .clk        (clk),
        .rst        (rst),
        .wb_start   (wb_start),
        .victim_tag (victim_tag),
        .addr       (addr),
        .line_data  (line_data),
        .wr_req_ok  (wr_req_ok),
        .wr_ready   (wr_ready),
        .wr_resp    (wr_resp),
        .wb_busy    (wb_busy),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_valid   (wr_valid),
        .wr_last    (wr_last)
    );

    // One bank per word offset
    for (genvar w = 0; w < `DC_WORDS; w++) begin : g_bank
        word_bank #(
            .LINES (`DC_LINES)
        ) i_bank (
            .clk   (clk),
            .index (index),
            .we    (bank_we[w]),
            .be    (bank_be),
            .wdata (bank_wdata[w]),
            .rdata (line_data[w])
        );
    end

endmodule

`default_nettype wire

// File: dv/dcache_tb.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT   = 400;
    localparam int MEM_WORDS = 4096;

    logic     clk;
    logic     rst;
    logic     req;
    addr_t    addr;
    byte_en_t be;
    word_t    wdata;
    logic     data_ok;
    word_t    rdata;
    logic     busy;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_req_ok;
    word_t    rd_data;
    logic     rd_valid;
    logic     rd_last;
    logic     wr_req;
    addr_t    wr_addr;
    logic     wr_req_ok;
    word_t    wr_data;
    logic     wr_valid;
    logic     wr_last;
    logic     wr_ready;
    logic     wr_resp;

    word_t mem    [MEM_WORDS];    // Backing memory behind the bursts
    word_t shadow [MEM_WORDS];    // Memory as the processor sees it

    // Expected cache contents per line
    logic  ref_valid [`DC_LINES];
    logic  ref_dirty [`DC_LINES];
    tag_t  ref_tag   [`DC_LINES];

    integer seed        = 32'h2218;
    int     errors      = 0;
    int     checks      = 0;
    int     rd_count    = 0;
    int     wb_count    = 0;
    logic   timed_out   = 1'b0;
    string  test_name   = "reset";
    logic   exp_miss    = 1'b0;
    logic   exp_wb      = 1'b0;
    addr_t  exp_rd_addr = '0;
    addr_t  exp_wr_addr = '0;

    dcache_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Address bits above bit 13 are outside the model and read as zero
    function automatic logic [11:0] word_index(input addr_t a);
        return a[13:2];
    endfunction

    function automatic word_t fill_pattern(input int i);
        logic [15:0] a;
        a = 16'(i * 4);
        return {~a, a};
    endfunction

    function automatic word_t read_ref(input addr_t a);
        return shadow[word_index(a)];
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input byte_en_t b);
        word_t w;
        w = old;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // Every load answer against the shadow memory
    always @(negedge clk) begin
        if (!rst && data_ok && be == '0) begin
            check_word({test_name, " load data"}, read_ref(addr), rdata);
        end
    end

    // One processor access from req to the edge after data_ok
    task automatic access(input addr_t a, input byte_en_t b, input word_t d);
        index_t idx;
        tag_t   tg;
        logic   exp_hit;
        logic   done;
        int     cycles;
        int     rd_before;
        int     wb_before;
        if (!timed_out) begin
            idx         = a[12:6];
            tg          = a[31:13];
            exp_hit     = ref_valid[idx] && ref_tag[idx] == tg;
            exp_miss    = !exp_hit;
            exp_wb      = !exp_hit && ref_valid[idx] && ref_dirty[idx];
            exp_rd_addr = {a[31:6], 6'b0};
            exp_wr_addr = {ref_tag[idx], idx, 6'b0};
            rd_before   = rd_count;
            wb_before   = wb_count;
            @(posedge clk);
            #1;
            req    = 1'b1;
            addr   = a;
            be     = b;
            wdata  = d;
            done   = 1'b0;
            cycles = 0;
            while (!done && cycles < TIMEOUT) begin
                @(negedge clk);
                if (cycles == 0) begin
                    check_flag({test_name, " hit"}, exp_hit, data_ok);  // Hits answer at once
                    check_flag({test_name, " read request"}, !exp_hit, rd_req);
                    check_flag({test_name, " writeback request"}, exp_wb, wr_req);
                end
                check_flag({test_name, " busy"}, !exp_hit, busy);
                done = data_ok;
                cycles++;
            end
            if (!done) begin
                $display("Timeout: no data_ok within %0d cycles in %s at address %h",
                         TIMEOUT, test_name, a);
                errors++;
                timed_out = 1'b1;
            end else begin
                if (b != '0) begin
                    shadow[word_index(a)] = merge_bytes(read_ref(a), d, b);
                end
                if (!exp_hit) begin
                    ref_valid[idx] = 1'b1;
                    ref_tag[idx]   = tg;
                    ref_dirty[idx] = |b;
                end else if (b != '0) begin
                    ref_dirty[idx] = 1'b1;
                end
                if (!exp_hit && rd_count != rd_before + 1) begin
                    $display("Miss in %s finished without a read burst", test_name);
                    errors++;
                end
                if (exp_wb && wb_count != wb_before + 1) begin
                    $display("Dirty victim in %s was not written back", test_name);
                    errors++;
                end
                @(posedge clk);
                #1;
                req = 1'b0;
            end
        end
    endtask

    // Memory read channel
    initial begin : read_channel
        addr_t base;
        word_t rnd;
        int    beat;
        int    cycles;
        rd_req_ok = 1'b0;
        rd_data   = '0;
        rd_valid  = 1'b0;
        rd_last   = 1'b0;
        forever begin
            @(negedge clk);
            if (rd_req && rd_req_ok) begin
                if (!exp_miss) begin
                    $display("Read request for address %h during a hit", rd_addr);
                    errors++;
                end
                check_addr({test_name, " refill address"}, exp_rd_addr, rd_addr);
                rd_count++;
                base   = rd_addr;
                beat   = 0;
                cycles = 0;
                @(posedge clk);
                #1;
                rd_req_ok = 1'b0;
                while (beat < 16 && cycles < TIMEOUT) begin
                    rnd      = $random(seed);
                    rd_valid = rnd[1:0] != 2'b00;   // Random gaps between beats
                    rd_data  = mem[word_index(base + addr_t'(beat * 4))];
                    rd_last  = rd_valid && beat == 15;
                    if (rd_valid) begin
                        beat++;
                    end
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (beat < 16) begin
                    $display("Read burst at %h stopped after %0d beats", base, beat);
                    errors++;
                end
                rd_valid = 1'b0;
                rd_last  = 1'b0;
            end else begin
                @(posedge clk);
                #1;
                rnd       = $random(seed);
                rd_req_ok = rnd[1:0] != 2'b00;
            end
        end
    end

    // Memory write channel
    initial begin : write_channel
        addr_t base;
        word_t rnd;
        int    beat;
        int    cycles;
        int    gap;
        wr_req_ok = 1'b0;
        wr_ready  = 1'b0;
        wr_resp   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_pattern(i);
        end
        forever begin
            @(negedge clk);
            if (wr_req && wr_req_ok) begin
                if (!exp_wb) begin
                    $display("Writeback request for address %h while none was due", wr_addr);
                    errors++;
                end
                check_addr({test_name, " writeback address"}, exp_wr_addr, wr_addr);
                base   = wr_addr;
                beat   = 0;
                cycles = 0;
                @(posedge clk);
                #1;
                wr_req_ok = 1'b0;
                while (beat < 16 && cycles < TIMEOUT) begin
                    rnd      = $random(seed);
                    wr_ready = rnd[1:0] != 2'b00;
                    @(negedge clk);
                    if (wr_valid && wr_ready) begin
                        check_word({test_name, " writeback data"},
                                   read_ref(base + addr_t'(beat * 4)), wr_data);
                        check_flag({test_name, " writeback last"}, beat == 15, wr_last);
                        mem[word_index(base + addr_t'(beat * 4))] = wr_data;
                        beat++;
                    end
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                wr_ready = 1'b0;
                if (beat < 16) begin
                    $display("Writeback burst at %h stalled after %0d beats", base, beat);
                    errors++;
                end
                rnd = $random(seed);
                gap = int'(rnd[1:0]);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                wr_resp = 1'b1;
                @(posedge clk);
                #1;
                wr_resp = 1'b0;
                wb_count++;
            end else begin
                @(posedge clk);
                #1;
                rnd       = $random(seed);
                wr_req_ok = rnd[1:0] != 2'b00;
            end
        end
    end

    initial begin : main
        word_t    rnd;
        addr_t    a;
        byte_en_t b;
        rst   = 1'b1;
        req   = 1'b0;
        addr  = '0;
        be    = '0;
        wdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_pattern(i);
        end
        for (int i = 0; i < `DC_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset rd_req", 1'b0, rd_req);
        check_flag("reset wr_req", 1'b0, wr_req);
        check_flag("reset wr_valid", 1'b0, wr_valid);
        check_flag("reset data_ok", 1'b0, data_ok);

        test_name = "first load miss";
        access(32'h0000_0084, 4'b0000, 32'h0);
        test_name = "load hit same line";
        access(32'h0000_00b0, 4'b0000, 32'h0);
        test_name = "store hit";
        access(32'h0000_0088, 4'b0110, 32'hdead_beef);
        access(32'h0000_0088, 4'b0000, 32'h0);
        test_name = "store miss";
        access(32'h0000_0104, 4'b1001, 32'h1234_5678);
        access(32'h0000_0104, 4'b0000, 32'h0);
        access(32'h0000_013c, 4'b0000, 32'h0);
        test_name = "dirty eviction";
        access(32'h0000_2084, 4'b0000, 32'h0);
        access(32'h0000_0088, 4'b0000, 32'h0);   // Refill sees the written-back line
        access(32'h0000_2100, 4'b1111, 32'h0bad_cafe);
        access(32'h0000_0104, 4'b0000, 32'h0);

        // Two tags over four lines keep evictions frequent
        test_name = "random mix";
        for (int n = 0; n < 300; n++) begin
            rnd = $random(seed);
            a   = {18'd0, rnd[2], 5'd0, rnd[1:0], rnd[6:3], 2'b00};
            b   = rnd[7] ? rnd[11:8] : 4'b0000;
            access(a, b, $random(seed));
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_top.f
+incdir+hw
hw/dcache_pkg.sv
hw/tag_store.sv
hw/word_bank.sv
hw/line_fill.sv
hw/line_writeback.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := dcache_tb
FILELIST := dcache_top.f
OBJ_DIR  := obj_dir
PASS     := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The output is printed and then searched for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
